// File: project.f
+incdir+common
common/dsp_types_pkg.sv
common/dsp_cfg_pkg.sv
common/dsp_op_if.sv
dsp/dsp_input_stage.sv
dsp/dsp_multiplier.sv
dsp/dsp_accumulator.sv
dsp/dsp_output_stage.sv
verilog/dsp_slice.sv
dv/dsp_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module dsp_tb -f project.f -o dsp_sim &&
./obj_dir/dsp_sim | tee /dev/stderr | grep "^PASS: all tests$" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// File: dv/dsp_tb.sv
`timescale 1ns/10ps
`include "dsp_macros.svh"

module dsp_tb;

    // Coefficient 3 is negative
    localparam dsp_cfg_pkg::coef_set_t TB_COEFFS = {20'hFFF85, 20'h01A2B, 20'h70001, 20'h00123};

    logic                      clock_i;
    logic                      s_reset;
    dsp_types_pkg::operand_a_t a;
    dsp_types_pkg::operand_b_t b;
    dsp_types_pkg::shift_t     acc_fir;
    dsp_cfg_pkg::feedback_e    feedback;
    logic                      load_acc;
    logic                      unsigned_a;
    logic                      unsigned_b;
    logic                      sat_en;
    dsp_types_pkg::shift_t     shift_right;
    logic                      rnd_en;
    logic                      subtract;
    dsp_cfg_pkg::out_sel_e     out_sel;
    logic                      reg_in;
    dsp_types_pkg::z_t         z;
    dsp_types_pkg::operand_b_t dly_b;

    int checks;
    int errors;
    int timeouts;

    dsp_slice #(
        .COEFFS (TB_COEFFS)
    ) dut0 (
        .clock_i           (clock_i),
        .s_reset           (s_reset),
        .a_i               (a),
        .b_i               (b),
        .acc_fir_i         (acc_fir),
        .feedback_i        (feedback),
        .load_acc_i        (load_acc),
        .unsigned_a_i      (unsigned_a),
        .unsigned_b_i      (unsigned_b),
        .saturate_enable_i (sat_en),
        .shift_right_i     (shift_right),
        .round_i           (rnd_en),
        .subtract_i        (subtract),
        .output_select_i   (out_sel),
        .register_inputs_i (reg_in),
        .z_o               (z),
        .dly_b_o           (dly_b)
    );

    initial begin
        clock_i = 1'b0;
        forever #20 clock_i = ~clock_i;
    end

    // Inputs change 2 ns after the rising edge
    task automatic tick();
        @(posedge clock_i);
        #2;
    endtask

    // Outputs are sampled on the falling edge
    task automatic settle();
        @(negedge clock_i);
    endtask

    task automatic wait_known(input int limit);
        int n;
        n = 0;
        while ((^z === 1'bx || ^dly_b === 1'bx) && n < limit) begin
            tick();
            n++;
        end
        if (^z === 1'bx || ^dly_b === 1'bx) begin
            timeouts++;
            $display("Timeout: outputs still unknown %0d cycles after reset", limit);
        end
    endtask

    task automatic check_z(input dsp_types_pkg::z_t got, input dsp_types_pkg::z_t exp,
                           input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s z_o=%h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_b(input dsp_types_pkg::operand_b_t got,
                           input dsp_types_pkg::operand_b_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s dly_b_o=%h expected %h", $time, what, got, exp);
        end
    endtask

    function automatic dsp_types_pkg::operand_a_t rand_a();
        logic [31:0] r;
        r = $urandom();
        return r[`DSP_A_W-1:0];
    endfunction

    function automatic dsp_types_pkg::operand_b_t rand_b();
        logic [31:0] r;
        r = $urandom();
        return r[`DSP_B_W-1:0];
    endfunction

    // Exact product of both operands widened by their own signedness
    function automatic longint ref_product(input dsp_types_pkg::operand_a_t av,
                                           input dsp_types_pkg::operand_b_t bv,
                                           input logic ua, input logic ub);
        longint xa;
        longint xb;
        xa = ua ? longint'(av) : longint'($signed(av));
        xb = ub ? longint'(bv) : longint'($signed(bv));
        return xa * xb;
    endfunction

    function automatic longint ref_addend(input dsp_types_pkg::operand_a_t av, input logic ua,
                                          input int fir);
        longint xa;
        xa = ua ? longint'(av) : longint'($signed(av));
        return xa <<< fir;
    endfunction

    function automatic dsp_types_pkg::z_t ref_post(input longint v, input int sh,
                                                   input logic rnd, input logic sat,
                                                   input logic uns);
        longint r;
        longint max_s;
        longint min_s;
        longint max_u;
        max_s = (longint'(1) <<< (`DSP_Z_W - 1)) - 1;
        min_s = -(longint'(1) <<< (`DSP_Z_W - 1));
        max_u = (longint'(1) <<< `DSP_Z_W) - 1;
        r = v >>> sh;
        if (rnd && sh != 0) begin
            r = r + ((v >>> (sh - 1)) & 1);
        end
        if (sat && uns) begin
            if (r < 0) begin
                r = 0;
            end else if (r > max_u) begin
                r = max_u;
            end
        end else if (sat) begin
            if (r > max_s) begin
                r = max_s;
            end else if (r < min_s) begin
                r = min_s;
            end
        end
        return r[`DSP_Z_W-1:0];
    endfunction

    // Clear the accumulator and add count signed products av*bv
    task automatic load_products(input dsp_types_pkg::operand_a_t av,
                                 input dsp_types_pkg::operand_b_t bv, input int count);
        int j;
        tick();
        a          = '0;
        b          = '0;
        unsigned_a = 1'b0;
        unsigned_b = 1'b0;
        feedback   = dsp_cfg_pkg::FB_ADD_ZERO;
        load_acc   = 1'b1;
        for (j = 0; j < count; j++) begin
            tick();
            a        = av;
            b        = bv;
            feedback = dsp_cfg_pkg::FB_ACC;
        end
        tick();
        load_acc = 1'b0;
    endtask

    task automatic test_reset();
        wait_known(8);
        settle();
        check_z(z, '0, "reset");
        check_b(dly_b, '0, "reset");
    endtask

    task automatic test_multiply();
        dsp_types_pkg::operand_a_t ha [16];
        dsp_types_pkg::operand_b_t hb [16];
        logic                      hua [16];
        logic                      hub [16];
        dsp_types_pkg::operand_b_t last_b;
        dsp_types_pkg::operand_b_t exp_b;
        longint                    p;
        int                        pass_i;
        int                        lat;
        int                        i;
        tick();
        out_sel  = dsp_cfg_pkg::OUT_MULT_REG;
        feedback = dsp_cfg_pkg::FB_ADD_ZERO;
        load_acc = 1'b0;
        subtract = 1'b0;
        for (pass_i = 0; pass_i < 2; pass_i++) begin
            lat    = 1 + pass_i;
            last_b = b;
            for (i = 0; i < 16; i++) begin
                tick();
                reg_in     = pass_i[0];
                ha[i]      = rand_a();
                hb[i]      = rand_b();
                // Cycle through signed, mixed and unsigned operands
                hua[i]     = i[0];
                hub[i]     = i[1];
                a          = ha[i];
                b          = hb[i];
                unsigned_a = hua[i];
                unsigned_b = hub[i];
                settle();
                if (i >= lat) begin
                    p = ref_product(ha[i-lat], hb[i-lat], hua[i-lat], hub[i-lat]);
                    check_z(z, p[`DSP_Z_W-1:0], "multiply");
                end
                exp_b = (i == 0) ? last_b : hb[i-1];
                check_b(dly_b, exp_b, "delayed b");
            end
        end
        tick();
        reg_in = 1'b0;
    endtask

    task automatic test_fir();
        longint p;
        longint sum;
        int     k;
        int     s;
        int     n;
        tick();
        out_sel    = dsp_cfg_pkg::OUT_ADD_REG;
        unsigned_a = 1'b0;
        unsigned_b = 1'b0;
        load_acc   = 1'b0;
        for (k = 0; k < 4; k++) begin
            for (s = 0; s < 2; s++) begin
                for (n = 0; n < 3; n++) begin
                    tick();
                    a        = rand_a();
                    b        = rand_b();
                    acc_fir  = dsp_types_pkg::shift_t'(5 * n);
                    feedback = dsp_cfg_pkg::feedback_e'(4 + k);
                    subtract = s[0];
                    tick();
                    settle();
                    p = ref_product(TB_COEFFS[k], b, 1'b0, 1'b0);
                    if (s == 1) begin
                        p = -p;
                    end
                    sum = p + ref_addend(a, 1'b0, 5 * n);
                    check_z(z, sum[`DSP_Z_W-1:0], "fir");
                end
            end
        end
        tick();
        subtract = 1'b0;
        acc_fir  = '0;
    endtask

    task automatic test_accumulate();
        longint model_acc;
        longint p;
        int     i;
        tick();
        out_sel    = dsp_cfg_pkg::OUT_ACC;
        unsigned_a = 1'b0;
        unsigned_b = 1'b0;
        a          = '0;
        b          = '0;
        feedback   = dsp_cfg_pkg::FB_ADD_ZERO;
        load_acc   = 1'b1;
        model_acc  = 0;
        for (i = 0; i < 8; i++) begin
            tick();
            a        = rand_a();
            b        = rand_b();
            feedback = dsp_cfg_pkg::FB_ACC;
            settle();
            check_z(z, model_acc[`DSP_Z_W-1:0], "accumulate");
            model_acc = model_acc + ref_product(a, b, 1'b0, 1'b0);
        end
        tick();
        load_acc = 1'b0;
        for (i = 0; i < 4; i++) begin
            settle();
            check_z(z, model_acc[`DSP_Z_W-1:0], "accumulator hold");
            tick();
            a = rand_a();
            b = rand_b();
        end
        // Accumulator low bits as multiplier A
        out_sel  = dsp_cfg_pkg::OUT_MULT;
        feedback = dsp_cfg_pkg::FB_ACC_A;
        for (i = 0; i < 3; i++) begin
            tick();
            b = rand_b();
            settle();
            p = ref_product(model_acc[`DSP_A_W-1:0], b, 1'b0, 1'b0);
            check_z(z, p[`DSP_Z_W-1:0], "acc feedback multiply");
        end
    endtask

    task automatic test_post();
        dsp_types_pkg::operand_a_t vals [2];
        int                        shifts [6];
        longint                    model_acc;
        int                        v;
        int                        i;
        int                        r;
        vals   = '{20'h5A3C7, 20'hA5C39};
        shifts = '{0, 1, 4, 9, 17, 31};
        tick();
        out_sel = dsp_cfg_pkg::OUT_ACC;
        sat_en  = 1'b0;
        for (v = 0; v < 2; v++) begin
            load_products(vals[v], 18'h02D41, 1);
            model_acc = ref_product(vals[v], 18'h02D41, 1'b0, 1'b0);
            for (i = 0; i < 6; i++) begin
                for (r = 0; r < 2; r++) begin
                    tick();
                    shift_right = dsp_types_pkg::shift_t'(shifts[i]);
                    rnd_en      = r[0];
                    tick();
                    settle();
                    check_z(z, ref_post(model_acc, shifts[i], r[0], 1'b0, 1'b0), "shift round");
                end
            end
        end
        // Five near-full products overflow both result ranges
        vals = '{20'h7FFFF, 20'h80000};
        for (v = 0; v < 2; v++) begin
            tick();
            shift_right = '0;
            rnd_en      = 1'b0;
            sat_en      = 1'b0;
            load_products(vals[v], 18'h1FFFF, 5);
            model_acc = 5 * ref_product(vals[v], 18'h1FFFF, 1'b0, 1'b0);
            tick();
            sat_en = 1'b1;
            tick();
            settle();
            check_z(z, ref_post(model_acc, 0, 1'b0, 1'b1, 1'b0), "signed saturate");
            tick();
            unsigned_a = 1'b1;
            unsigned_b = 1'b1;
            tick();
            settle();
            check_z(z, ref_post(model_acc, 0, 1'b0, 1'b1, 1'b1), "unsigned saturate");
        end
        tick();
        sat_en     = 1'b0;
        unsigned_a = 1'b0;
        unsigned_b = 1'b0;
    endtask

    initial begin
        checks      = 0;
        errors      = 0;
        timeouts    = 0;
        void'($urandom(32'h4d8f));
        s_reset     = 1'b1;
        a           = '0;
        b           = '0;
        acc_fir     = '0;
        feedback    = dsp_cfg_pkg::FB_ACC;
        load_acc    = 1'b0;
        unsigned_a  = 1'b0;
        unsigned_b  = 1'b0;
        sat_en      = 1'b0;
        shift_right = '0;
        rnd_en      = 1'b0;
        subtract    = 1'b0;
        out_sel     = dsp_cfg_pkg::OUT_ACC_REG;
        reg_in      = 1'b0;
        repeat (2) @(posedge clock_i);
        #2;
        s_reset = 1'b0;

        test_reset();
        test_multiply();
        test_fir();
        test_accumulate();
        test_post();

        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: verilog/dsp_slice.sv
`timescale 1ns/10ps

module dsp_slice #(
    parameter dsp_cfg_pkg::coef_set_t COEFFS = '0
) (
    input  logic                      clock_i,
    input  logic                      s_reset,
    input  dsp_types_pkg::operand_a_t a_i,
    input  dsp_types_pkg::operand_b_t b_i,
    input  dsp_types_pkg::shift_t     acc_fir_i,
    input  dsp_cfg_pkg::feedback_e    feedback_i,
    input  logic                      load_acc_i,
    input  logic                      unsigned_a_i,
    input  logic                      unsigned_b_i,
    input  logic                      saturate_enable_i,
    input  dsp_types_pkg::shift_t     shift_right_i,
    input  logic                      round_i,
    input  logic                      subtract_i,
    input  dsp_cfg_pkg::out_sel_e     output_select_i,
    input  logic                      register_inputs_i,
    output dsp_types_pkg::z_t         z_o,
    output dsp_types_pkg::operand_b_t dly_b_o
);

    dsp_op_if op_if ();

    dsp_types_pkg::acc_t   product_xtnd;
    dsp_types_pkg::acc_t   add_sum;
    dsp_types_pkg::acc_t   acc_q;
    dsp_types_pkg::shift_t shift_d1;
    logic                  round_d1;
    logic                  sat_d1;

    dsp_input_stage u_input (
        .clock_i           (clock_i),
        .s_reset           (s_reset),
        .a_i               (a_i),
        .b_i               (b_i),
        .acc_fir_i         (acc_fir_i),
        .feedback_i        (feedback_i),
        .load_acc_i        (load_acc_i),
        .unsigned_a_i      (unsigned_a_i),
        .unsigned_b_i      (unsigned_b_i),
        .saturate_enable_i (saturate_enable_i),
        .shift_right_i     (shift_right_i),
        .round_i           (round_i),
        .subtract_i        (subtract_i),
        .register_inputs_i (register_inputs_i),
        .op                (op_if),
        .shift_d1_o        (shift_d1),
        .round_d1_o        (round_d1),
        .sat_d1_o          (sat_d1),
        .dly_b_o           (dly_b_o)
    );

    dsp_multiplier #(
        .COEFFS (COEFFS)
    ) u_mult (
        .op             (op_if),
        .acc_q_i        (acc_q),
        .product_xtnd_o (product_xtnd)
    );

    dsp_accumulator u_accum (
        .clock_i        (clock_i),
        .s_reset        (s_reset),
        .op             (op_if),
        .product_xtnd_i (product_xtnd),
        .add_sum_o      (add_sum),
        .acc_q_o        (acc_q)
    );

    dsp_output_stage u_output (
        .clock_i         (clock_i),
        .s_reset         (s_reset),
        .op              (op_if),
        .output_select_i (output_select_i),
        .product_xtnd_i  (product_xtnd),
        .add_sum_i       (add_sum),
        .acc_q_i         (acc_q),
        .shift_d1_i      (shift_d1),
        .round_d1_i      (round_d1),
        .sat_d1_i        (sat_d1),
        .z_o             (z_o)
    );

endmodule

// File: dsp/dsp_output_stage.sv
`timescale 1ns/10ps
`include "dsp_macros.svh"

module dsp_output_stage (
    input  logic                  clock_i,
    input  logic                  s_reset,
    dsp_op_if.post                op,
    input  dsp_cfg_pkg::out_sel_e output_select_i,
    input  dsp_types_pkg::acc_t   product_xtnd_i,
    input  dsp_types_pkg::acc_t   add_sum_i,
    input  dsp_types_pkg::acc_t   acc_q_i,
    input  dsp_types_pkg::shift_t shift_d1_i,
    input  logic                  round_d1_i,
    input  logic                  sat_d1_i,
    output dsp_types_pkg::z_t     z_o
);

    dsp_types_pkg::shift_t r_shift_d2;
    logic                  r_round_d2;
    logic                  r_sat_d2;
    dsp_types_pkg::shift_t shift_d2;
    logic                  round_d2;
    logic                  sat_d2;
    logic                  use_add;
    logic                  unsigned_mode;
    logic                  round_bit;
    dsp_types_pkg::acc_t   acc_out;
    dsp_types_pkg::acc_t   acc_shr;
    dsp_types_pkg::acc_t   acc_rnd;
    dsp_types_pkg::z_t     sat_s;
    dsp_types_pkg::z_t     sat_u;
    dsp_types_pkg::z_t     z_mult;
    dsp_types_pkg::z_t     z_post;
    dsp_types_pkg::z_t     z_reg;

    always_ff @(posedge clock_i or posedge s_reset) begin
        if (s_reset) begin
            r_shift_d2 <= '0;
            r_round_d2 <= 1'b0;
            r_sat_d2   <= 1'b0;
        end else begin
            r_shift_d2 <= shift_d1_i;
            r_round_d2 <= round_d1_i;
            r_sat_d2   <= sat_d1_i;
        end
    end

    // Accumulator path sees controls one cycle later, matching the load edge
    assign use_add  = output_select_i[1];
    assign shift_d2 = use_add ? shift_d1_i : r_shift_d2;
    assign round_d2 = use_add ? round_d1_i : r_round_d2;
    assign sat_d2   = use_add ? sat_d1_i   : r_sat_d2;

    assign acc_out = use_add ? add_sum_i : acc_q_i;
    assign acc_shr = acc_out >>> shift_d2;

    // Last bit shifted out
    assign round_bit = (shift_d2 != '0) ? acc_out[shift_d2 - 1'b1] : 1'b0;
    assign acc_rnd   = (round_d2 && round_bit) ? (acc_shr + 1'b1) : acc_shr;

    assign unsigned_mode = op.unsigned_a & op.unsigned_b;

    always_comb begin
        if ((|acc_rnd[`DSP_ACC_W-1:`DSP_Z_W-1]) == 1'b0 ||
            (&acc_rnd[`DSP_ACC_W-1:`DSP_Z_W-1]) == 1'b1) begin
            sat_s = acc_rnd[`DSP_Z_W-1:0];
        end else begin
            sat_s = {acc_rnd[`DSP_ACC_W-1], {(`DSP_Z_W-1){~acc_rnd[`DSP_ACC_W-1]}}};
        end
    end

    always_comb begin
        if (acc_rnd[`DSP_ACC_W-1]) begin
            sat_u = '0;
        end else if (|acc_rnd[`DSP_ACC_W-1:`DSP_Z_W]) begin
            sat_u = '1;
        end else begin
            sat_u = acc_rnd[`DSP_Z_W-1:0];
        end
    end

    assign z_mult = product_xtnd_i[`DSP_Z_W-1:0];
    assign z_post = !sat_d2      ? acc_rnd[`DSP_Z_W-1:0] :
                    unsigned_mode ? sat_u : sat_s;

    always_ff @(posedge clock_i or posedge s_reset) begin
        if (s_reset) begin
            z_reg <= '0;
        end else if (output_select_i == dsp_cfg_pkg::OUT_MULT_REG) begin
            z_reg <= z_mult;
        end else begin
            z_reg <= z_post;
        end
    end

    // Output mux
    always_comb begin
        if (output_select_i == dsp_cfg_pkg::OUT_MULT) begin
            z_o = z_mult;
        end else if (output_select_i[0]) begin
            z_o = z_reg;
        end else begin
            z_o = z_post;
        end
    end

endmodule

// File: dsp/dsp_accumulator.sv
`timescale 1ns/10ps
`include "dsp_macros.svh"

module dsp_accumulator (
    input  logic                clock_i,
    input  logic                s_reset,
    dsp_op_if.accum             op,
    input  dsp_types_pkg::acc_t product_xtnd_i,
    output dsp_types_pkg::acc_t add_sum_o,
    output dsp_types_pkg::acc_t acc_q_o
);

    localparam int A_XTND_W = `DSP_ACC_W - `DSP_A_W;

    dsp_types_pkg::acc_t add_a;
    dsp_types_pkg::acc_t add_b;
    dsp_types_pkg::acc_t a_xtnd;

    assign add_a = op.subtract ? (~product_xtnd_i + 1'b1) : product_xtnd_i;

    // A widened by its own signedness for the FIR pre-shift
    assign a_xtnd = op.unsigned_a ? {{A_XTND_W{1'b0}}, op.a} :
                                    {{A_XTND_W{op.a[`DSP_A_W-1]}}, op.a};

    always_comb begin
        case (op.feedback)
            dsp_cfg_pkg::FB_ACC:      add_b = acc_q_o;
            dsp_cfg_pkg::FB_ADD_ZERO: add_b = '0;
            default:                  add_b = a_xtnd << op.acc_fir;
        endcase
    end

    assign add_sum_o = add_a + add_b;

    always_ff @(posedge clock_i or posedge s_reset) begin
        if (s_reset) begin
            acc_q_o <= '0;
        end else if (op.load_acc) begin
            acc_q_o <= add_sum_o;
        end
    end

endmodule

// File: dsp/dsp_multiplier.sv
`timescale 1ns/10ps
`include "dsp_macros.svh"

module dsp_multiplier #(
    parameter dsp_cfg_pkg::coef_set_t COEFFS = '0
) (
    dsp_op_if.mult                op,
    input  dsp_types_pkg::acc_t   acc_q_i,
    output dsp_types_pkg::acc_t   product_xtnd_o
);

    localparam int XTND_W = `DSP_ACC_W - `DSP_A_W - `DSP_B_W;

    dsp_types_pkg::operand_a_t mult_a;
    dsp_types_pkg::operand_b_t mult_b;
    dsp_types_pkg::operand_a_t mag_a;
    dsp_types_pkg::operand_b_t mag_b;
    dsp_types_pkg::product_t   mag_p;
    dsp_types_pkg::product_t   prod;
    logic                      neg_a;
    logic                      neg_b;
    logic                      unsigned_mode;

    // Multiplier A source
    always_comb begin
        case (op.feedback)
            dsp_cfg_pkg::FB_ACC_A: mult_a = acc_q_i[`DSP_A_W-1:0];
            dsp_cfg_pkg::FB_COEF0: mult_a = COEFFS[0];
            dsp_cfg_pkg::FB_COEF1: mult_a = COEFFS[1];
            dsp_cfg_pkg::FB_COEF2: mult_a = COEFFS[2];
            dsp_cfg_pkg::FB_COEF3: mult_a = COEFFS[3];
            default:               mult_a = op.a;
        endcase
    end

    assign mult_b = (op.feedback == dsp_cfg_pkg::FB_ZERO_B) ? '0 : op.b;

    // Sign-magnitude split, unsigned operands are their own magnitude
    assign neg_a = mult_a[`DSP_A_W-1] & ~op.unsigned_a;
    assign neg_b = mult_b[`DSP_B_W-1] & ~op.unsigned_b;
    assign mag_a = neg_a ? (~mult_a + 1'b1) : mult_a;
    assign mag_b = neg_b ? (~mult_b + 1'b1) : mult_b;

    assign mag_p = mag_a * mag_b;
    assign prod  = (neg_a ^ neg_b) ? (~mag_p + 1'b1) : mag_p;

    // Full 38-bit product only when both are unsigned
    assign unsigned_mode = op.unsigned_a & op.unsigned_b;

    assign product_xtnd_o = unsigned_mode ?
        {{XTND_W{1'b0}}, prod} :
        {{XTND_W{prod[`DSP_A_W+`DSP_B_W-1]}}, prod};

endmodule

// File: dsp/dsp_input_stage.sv
`timescale 1ns/10ps

module dsp_input_stage (
    input  logic                      clock_i,
    input  logic                      s_reset,
    input  dsp_types_pkg::operand_a_t a_i,
    input  dsp_types_pkg::operand_b_t b_i,
    input  dsp_types_pkg::shift_t     acc_fir_i,
    input  dsp_cfg_pkg::feedback_e    feedback_i,
    input  logic                      load_acc_i,
    input  logic                      unsigned_a_i,
    input  logic                      unsigned_b_i,
    input  logic                      saturate_enable_i,
    input  dsp_types_pkg::shift_t     shift_right_i,
    input  logic                      round_i,
    input  logic                      subtract_i,
    input  logic                      register_inputs_i,
    dsp_op_if.src                     op,
    output dsp_types_pkg::shift_t     shift_d1_o,
    output logic                      round_d1_o,
    output logic                      sat_d1_o,
    output dsp_types_pkg::operand_b_t dly_b_o
);

    dsp_types_pkg::operand_a_t r_a;
    dsp_types_pkg::operand_b_t r_b;
    dsp_types_pkg::shift_t     r_acc_fir;
    dsp_cfg_pkg::feedback_e    r_feedback;
    logic                      r_load_acc;
    logic                      r_unsigned_a;
    logic                      r_unsigned_b;
    logic                      r_subtract;
    dsp_types_pkg::shift_t     r_shift;
    logic                      r_round;
    logic                      r_sat;

    // Sampled every edge, used only when register_inputs_i is set
    always_ff @(posedge clock_i or posedge s_reset) begin
        if (s_reset) begin
            r_a          <= '0;
            r_b          <= '0;
            r_acc_fir    <= '0;
            r_feedback   <= dsp_cfg_pkg::FB_ACC;
            r_load_acc   <= 1'b0;
            r_unsigned_a <= 1'b0;
            r_unsigned_b <= 1'b0;
            r_subtract   <= 1'b0;
            r_shift      <= '0;
            r_round      <= 1'b0;
            r_sat        <= 1'b0;
            dly_b_o      <= '0;
        end else begin
            r_a          <= a_i;
            r_b          <= b_i;
            r_acc_fir    <= acc_fir_i;
            r_feedback   <= feedback_i;
            r_load_acc   <= load_acc_i;
            r_unsigned_a <= unsigned_a_i;
            r_unsigned_b <= unsigned_b_i;
            r_subtract   <= subtract_i;
            r_shift      <= shift_right_i;
            r_round      <= round_i;
            r_sat        <= saturate_enable_i;
            // Free-running B delay
            dly_b_o      <= b_i;
        end
    end

    always_comb begin
        if (register_inputs_i) begin
            op.a          = r_a;
            op.b          = r_b;
            op.acc_fir    = r_acc_fir;
            op.feedback   = r_feedback;
            op.load_acc   = r_load_acc;
            op.unsigned_a = r_unsigned_a;
            op.unsigned_b = r_unsigned_b;
            op.subtract   = r_subtract;
            shift_d1_o    = r_shift;
            round_d1_o    = r_round;
            sat_d1_o      = r_sat;
        end else begin
            op.a          = a_i;
            op.b          = b_i;
            op.acc_fir    = acc_fir_i;
            op.feedback   = feedback_i;
            op.load_acc   = load_acc_i;
            op.unsigned_a = unsigned_a_i;
            op.unsigned_b = unsigned_b_i;
            op.subtract   = subtract_i;
            shift_d1_o    = shift_right_i;
            round_d1_o    = round_i;
            sat_d1_o      = saturate_enable_i;
        end
    end

endmodule

// File: common/dsp_op_if.sv
`timescale 1ns/10ps

interface dsp_op_if;

    dsp_types_pkg::operand_a_t a;
    dsp_types_pkg::operand_b_t b;
    dsp_types_pkg::shift_t     acc_fir;
    logic                      unsigned_a;
    logic                      unsigned_b;
    dsp_cfg_pkg::feedback_e    feedback;
    logic                      load_acc;
    logic                      subtract;

    // Input stage, after the optional register
    modport src (
        output a, b, acc_fir, unsigned_a, unsigned_b, feedback, load_acc, subtract
    );

    modport mult (
        input a, b, unsigned_a, unsigned_b, feedback
    );

    modport accum (
        input a, acc_fir, unsigned_a, feedback, load_acc, subtract
    );

    // Saturation mode only
    modport post (
        input unsigned_a, unsigned_b
    );

endinterface

// File: common/dsp_cfg_pkg.sv
package dsp_cfg_pkg;

    // Multiplier A source and adder addend select
    typedef enum logic [2:0] {
        FB_ACC      = 3'd0,
        FB_ADD_ZERO = 3'd1,
        FB_ZERO_B   = 3'd2,
        FB_ACC_A    = 3'd3,
        FB_COEF0    = 3'd4,
        FB_COEF1    = 3'd5,
        FB_COEF2    = 3'd6,
        FB_COEF3    = 3'd7
    } feedback_e;

    // Bit 1 picks adder over accumulator, bit 0 picks the registered result
    typedef enum logic [2:0] {
        OUT_MULT      = 3'd0,
        OUT_MULT_REG  = 3'd1,
        OUT_ADD       = 3'd2,
        OUT_ADD_REG   = 3'd3,
        OUT_ACC       = 3'd4,
        OUT_ACC_REG   = 3'd5,
        OUT_ADD_6     = 3'd6,
        OUT_ADD_REG_7 = 3'd7
    } out_sel_e;

    // Fixed coefficients, index 0 matches FB_COEF0
    typedef dsp_types_pkg::operand_a_t [3:0] coef_set_t;

endpackage

// File: common/dsp_types_pkg.sv
`include "dsp_macros.svh"

package dsp_types_pkg;

    // Multiplier operands
    typedef logic [`DSP_A_W-1:0] operand_a_t;
    typedef logic [`DSP_B_W-1:0] operand_b_t;

    // Raw product before extension
    typedef logic [`DSP_A_W+`DSP_B_W-1:0] product_t;

    // Adder, accumulator and extended product word
    typedef logic signed [`DSP_ACC_W-1:0] acc_t;

    // Slice result
    typedef logic [`DSP_Z_W-1:0] z_t;

    // Right shift and FIR pre-shift amount
    typedef logic [`DSP_SHIFT_W-1:0] shift_t;

endpackage

// File: common/dsp_macros.svh
`ifndef DSP_MACROS_SVH
`define DSP_MACROS_SVH

// Operand widths
`define DSP_A_W 20
`define DSP_B_W 18

// Adder and accumulator width
`define DSP_ACC_W 64

// Result width after round, shift and saturate
`define DSP_Z_W 38

// Shift amount width, used by shift_right and acc_fir
`define DSP_SHIFT_W 6

`endif
